// ==== Makefile ====
# Verilator build and run of the tile core testbench

TOP := tb_nx4_tile_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

# the log decides pass or fail
run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
source/nx4_pkg.sv
source/nx4_register_bank.sv
source/nx4_clock_reset_gen.sv
source/nx4_memory_sequencer.sv
source/nx4_tile_core.sv
sim/tb_memory_model.sv
sim/tb_nx4_tile_core.sv

// ==== sim/tb_memory_model.sv ====
`default_nettype none

module tb_memory_model
    import nx4_pkg::*;
(
    input  wire logic                  clock,
    input  wire mem_pins_t             pins,
    output logic [MEM_DATA_W-1:0]      data_in
);

    timeunit 1ns;
    timeprecision 1ps;

    // sparse byte storage for both parts
    logic [MEM_DATA_W-1:0] sram_bytes [int];
    logic [MEM_DATA_W-1:0] flash_bytes [int];
    int                    sram_index;
    int                    flash_index;

    // sram is a 16 bit part, the lane comes from the byte enables
    assign sram_index  = int'({pins.addr[MEM_ADDR_W-2:0], !pins.sram_bhe_n});
    assign flash_index = int'(pins.addr);

    // unwritten bytes return a pattern built from every address bit
    function automatic logic [MEM_DATA_W-1:0] fill_byte(input int index);
        logic [31:0] a;
        a = index;
        return a[7:0] ^ a[15:8] ^ {3'b000, a[20:16]} ^ 8'h5a;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // read path
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        data_in = '0;
        if (!pins.sram_ce_n && !pins.sram_oe_n) begin
            if (sram_bytes.exists(sram_index)) begin
                data_in = sram_bytes[sram_index];
            end else begin
                data_in = fill_byte(sram_index);
            end
        end else if (!pins.flash_ce_n && !pins.flash_oe_n) begin
            if (flash_bytes.exists(flash_index)) begin
                data_in = flash_bytes[flash_index];
            end else begin
                data_in = fill_byte(flash_index);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////////////////////

    // pins sampled just before the edge
    // the byte held while we_n is low is the one latched when it rises
    always @(posedge clock) begin
        if (!pins.we_n && pins.data_oe) begin
            if (!pins.sram_ce_n) begin
                sram_bytes[sram_index] = pins.data_out;
            end
            if (!pins.flash_ce_n) begin
                flash_bytes[flash_index] = pins.data_out;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_nx4_tile_core.sv ====
`default_nettype none

module tb_nx4_tile_core
    import nx4_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                    clock = 1'b0;
    logic                    arst_n;
    reg_req_t                reg_req;
    status_pins_t            status;
    mem_req_t                mem_req;
    logic [REG_DATA_W-1:0]   reg_rdata;
    logic                    i2c_sda_drive_low;
    logic                    i2c_scl_drive_low;
    logic                    pixel_clock;
    logic                    grayscale_clock;
    logic                    core_reset;
    logic                    flash_reset_n;
    logic [MEM_DATA_W-1:0]   mem_rdata;
    logic                    mem_busy;
    mem_pins_t               mem_pins;
    logic [MEM_DATA_W-1:0]   mem_data_in;

    // reference model of the control bytes and both memories
    logic [REG_DATA_W-1:0]   ioctl_model;
    logic [REG_DATA_W-1:0]   drivectl_model;
    logic [REG_DATA_W-1:0]   upper_model;
    logic [MEM_DATA_W-1:0]   ref_sram [int];
    logic [MEM_DATA_W-1:0]   ref_flash [int];

    integer                  seed;
    int                      errors;
    int                      checks;
    int                      tests;

    // 40 ns period
    always #20 clock = ~clock;

    nx4_tile_core i_dut (
        .clock             (clock),
        .arst_n            (arst_n),
        .reg_req           (reg_req),
        .reg_rdata         (reg_rdata),
        .status            (status),
        .i2c_sda_drive_low (i2c_sda_drive_low),
        .i2c_scl_drive_low (i2c_scl_drive_low),
        .pixel_clock       (pixel_clock),
        .grayscale_clock   (grayscale_clock),
        .core_reset        (core_reset),
        .flash_reset_n     (flash_reset_n),
        .mem_req           (mem_req),
        .mem_rdata         (mem_rdata),
        .mem_busy          (mem_busy),
        .mem_pins          (mem_pins),
        .mem_data_in       (mem_data_in)
    );

    // external sram and flash
    tb_memory_model i_memory_model (
        .clock   (clock),
        .pins    (mem_pins),
        .data_in (mem_data_in)
    );

    ////////////////////////////////////////////////////////////////////////////
    // check and report helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout while waiting for %s at %0t", what, $time);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %s finished with %0d mismatches", name, errors - errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // register bus
    ////////////////////////////////////////////////////////////////////////////

    // readback rules of the register map
    function automatic logic [REG_DATA_W-1:0] expected_read(input logic [REG_ADDR_W-1:0] addr);
        logic [STATUS_W-1:0] bits;
        bits = status;
        case (addr)
            REG_IOCTL:     return ioctl_model;
            REG_DRIVECTL:  return drivectl_model;
            REG_MEM_UPPER: return upper_model;
            REG_STATUS_LO: return bits[7:0];
            REG_STATUS_HI: return {4'h0, bits[11:8]};
            default:       return 8'h00;
        endcase
    endfunction

    task automatic reg_write(input logic [REG_ADDR_W-1:0] addr,
                             input logic [REG_DATA_W-1:0] data);
        @(negedge clock);
        reg_req.write = 1'b1;
        reg_req.read  = 1'b0;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        @(negedge clock);
        reg_req = '0;
        // status and unused addresses keep nothing
        case (addr)
            REG_IOCTL:     ioctl_model    = data;
            REG_DRIVECTL:  drivectl_model = data;
            REG_MEM_UPPER: upper_model    = data;
            default: ;
        endcase
    endtask

    // fresh random status pins with every read
    task automatic reg_read_check(input logic [REG_ADDR_W-1:0] addr);
        logic [31:0]           r;
        logic [REG_DATA_W-1:0] expected;
        r = next_random();
        @(negedge clock);
        status        = r[STATUS_W-1:0];
        reg_req.read  = 1'b1;
        reg_req.write = 1'b0;
        reg_req.addr  = addr;
        expected      = expected_read(addr);
        @(negedge clock);
        reg_req = '0;
        compare($sformatf("reg_rdata[%0d]", addr), expected, reg_rdata);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // generated clocks
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic sample_clock(input logic gray);
        return gray ? grayscale_clock : pixel_clock;
    endfunction

    // cycles from one rising edge to the next
    task automatic measure_period(input logic gray, output int period);
        int   waited;
        int   rises;
        logic prev;
        logic now;
        period = 0;
        rises  = 0;
        waited = 0;
        // a new select reaches the pin one clock after the write
        @(negedge clock);
        prev   = sample_clock(gray);
        while (rises < 2 && waited < 1000) begin
            @(negedge clock);
            waited++;
            now = sample_clock(gray);
            if (rises == 1) begin
                period++;
            end
            if (now && !prev) begin
                rises++;
            end
            prev = now;
        end
        if (rises < 2) begin
            report_timeout(gray ? "grayscale_clock edges" : "pixel_clock edges");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // memory cycles
    ////////////////////////////////////////////////////////////////////////////

    task automatic mem_cycle(input logic use_flash, input logic use_sram, input logic we,
                             input logic [CMD_ADDR_W-1:0] addr,
                             input logic [MEM_DATA_W-1:0] wdata);
        logic [UPPER_ADDR_W-1:0] upper;
        logic [MEM_ADDR_W-1:0]   exp_addr;
        logic [MEM_DATA_W-1:0]   expected;
        logic                    saw_we_low;
        int                      key;
        int                      busy_cycles;
        int                      exp_cycles;
        upper = upper_model[UPPER_ADDR_W-1:0];
        key   = int'({upper, addr});
        // flash takes the byte address
        if (use_flash) begin
            exp_addr   = {upper, addr};
            exp_cycles = FLASH_CYCLES;
        end else begin
            // sram drops bit 0 into the lane enables
            exp_addr   = {1'b0, upper, addr[CMD_ADDR_W-1:1]};
            exp_cycles = SRAM_CYCLES;
        end
        @(negedge clock);
        mem_req.flash_strobe = use_flash;
        mem_req.sram_strobe  = use_sram;
        mem_req.we           = we;
        mem_req.addr         = addr;
        mem_req.wdata        = wdata;
        @(negedge clock);
        mem_req = '0;
        // first clock after the strobe edge
        compare("mem_pins.addr", exp_addr, mem_pins.addr);
        compare("mem_pins.flash_ce_n", !use_flash, mem_pins.flash_ce_n);
        compare("mem_pins.sram_ce_n", use_flash, mem_pins.sram_ce_n);
        compare("mem_pins.flash_oe_n", !(use_flash && !we), mem_pins.flash_oe_n);
        compare("mem_pins.sram_oe_n", !(!use_flash && !we), mem_pins.sram_oe_n);
        compare("mem_pins.data_oe", we, mem_pins.data_oe);
        if (!use_flash) begin
            compare("mem_pins.sram_bhe_n", !addr[0], mem_pins.sram_bhe_n);
            compare("mem_pins.sram_ble_n", addr[0], mem_pins.sram_ble_n);
        end
        if (we) begin
            compare("mem_pins.data_out", wdata, mem_pins.data_out);
        end
        // count busy clocks and watch for the write pulse
        busy_cycles = 0;
        saw_we_low  = 1'b0;
        while (mem_busy && busy_cycles < 20) begin
            busy_cycles++;
            if (!mem_pins.we_n) begin
                saw_we_low = 1'b1;
            end
            @(negedge clock);
        end
        if (mem_busy) begin
            report_timeout("mem_busy to fall");
        end else begin
            compare("mem_busy cycles", exp_cycles, busy_cycles);
        end
        compare("mem_pins.we_n", 1, mem_pins.we_n);
        compare("mem_pins.we_n low seen", we, saw_we_low);
        if (we) begin
            if (use_flash) begin
                ref_flash[key] = wdata;
            end else begin
                ref_sram[key] = wdata;
            end
        end else begin
            expected = use_flash ? ref_flash[key] : ref_sram[key];
            compare("mem_rdata", expected, mem_rdata);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        int errors_before;
        int cycles;
        int i;
        errors_before = errors;
        repeat (5) @(negedge clock);
        compare("core_reset", 1, core_reset);
        compare("flash_reset_n", 0, flash_reset_n);
        compare("mem_busy", 0, mem_busy);
        compare("mem_pins.we_n", 1, mem_pins.we_n);
        compare("mem_pins.sram_ce_n", 1, mem_pins.sram_ce_n);
        compare("mem_pins.sram_oe_n", 1, mem_pins.sram_oe_n);
        compare("mem_pins.flash_ce_n", 1, mem_pins.flash_ce_n);
        compare("mem_pins.flash_oe_n", 1, mem_pins.flash_oe_n);
        compare("mem_pins.data_oe", 0, mem_pins.data_oe);
        compare("i2c_sda_drive_low", 0, i2c_sda_drive_low);
        compare("i2c_scl_drive_low", 0, i2c_scl_drive_low);
        // ten clocks of reset in total
        repeat (5) @(negedge clock);
        arst_n = 1'b1;
        cycles = 0;
        while (core_reset && cycles < 20) begin
            @(negedge clock);
            cycles++;
        end
        if (core_reset) begin
            report_timeout("core_reset to fall");
        end else if (cycles < 8 || cycles > 9) begin
            errors++;
            $display("core_reset fell %0d cycles after reset release, not 8 or 9", cycles);
        end
        compare("flash_reset_n", 1, flash_reset_n);
        for (i = 0; i <= REG_STATUS_HI; i++) begin
            reg_read_check(REG_ADDR_W'(i));
        end
        finish_test("reset_state", errors_before);
    endtask

    task automatic run_register_traffic();
        logic [31:0] r;
        int          errors_before;
        int          i;
        errors_before = errors;
        for (i = 0; i < 64; i++) begin
            r = next_random();
            if (r[31]) begin
                reg_write(r[REG_ADDR_W-1:0], r[15:8]);
            end else begin
                reg_read_check(r[REG_ADDR_W-1:0]);
            end
        end
        // full sweep takes in the unused addresses
        for (i = 0; i < 16; i++) begin
            reg_read_check(REG_ADDR_W'(i));
        end
        finish_test("register_traffic", errors_before);
    endtask

    task automatic exercise_i2c_drive();
        logic [31:0] r;
        int          errors_before;
        errors_before = errors;
        repeat (12) begin
            r = next_random();
            reg_write(REG_IOCTL, r[7:0]);
            compare("i2c_sda_drive_low", !ioctl_model[IOCTL_BIT_SDA], i2c_sda_drive_low);
            compare("i2c_scl_drive_low", !ioctl_model[IOCTL_BIT_SCL], i2c_scl_drive_low);
        end
        finish_test("i2c_drive", errors_before);
    endtask

    task automatic measure_clock_selects();
        logic [31:0] r;
        int          errors_before;
        int          period;
        int          sel;
        errors_before = errors;
        repeat (6) begin
            r = next_random();
            reg_write(REG_DRIVECTL, r[7:0]);
            sel = drivectl_model[DRIVECTL_PCLK_LSB +: DRIVECTL_SEL_W];
            measure_period(1'b0, period);
            compare("pixel_clock period", 1 << (sel + 1), period);
            sel = drivectl_model[DRIVECTL_GCLK_LSB +: DRIVECTL_SEL_W];
            measure_period(1'b1, period);
            compare("grayscale_clock period", 1 << (sel + 1), period);
        end
        finish_test("clock_selects", errors_before);
    endtask

    task automatic run_memory_traffic();
        logic                  op_flash [$];
        logic [REG_DATA_W-1:0] op_upper [$];
        logic [CMD_ADDR_W-1:0] op_addr [$];
        logic [31:0]           r;
        int                    errors_before;
        int                    i;
        errors_before = errors;
        for (i = 0; i < 16; i++) begin
            r = next_random();
            op_flash.push_back(r[0]);
            op_upper.push_back(r[15:8]);
            op_addr.push_back(r[31:16]);
            r = next_random();
            reg_write(REG_MEM_UPPER, op_upper[i]);
            mem_cycle(op_flash[i], !op_flash[i], 1'b1, op_addr[i], r[7:0]);
        end
        // same locations read back with their own page
        for (i = 0; i < 16; i++) begin
            reg_write(REG_MEM_UPPER, op_upper[i]);
            mem_cycle(op_flash[i], !op_flash[i], 1'b0, op_addr[i], 8'h00);
        end
        finish_test("memory_traffic", errors_before);
    endtask

    // both strobes at once must run as flash
    task automatic check_strobe_priority();
        logic [31:0] r;
        int          errors_before;
        errors_before = errors;
        repeat (4) begin
            r = next_random();
            mem_cycle(1'b1, 1'b1, 1'b1, r[15:0], r[23:16]);
            mem_cycle(1'b1, 1'b1, 1'b0, r[15:0], 8'h00);
        end
        finish_test("strobe_priority", errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed           = 32'hcb2b_b9ea;
        arst_n         = 1'b0;
        reg_req        = '0;
        mem_req        = '0;
        status         = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        ioctl_model    = IOCTL_RESET;
        drivectl_model = DRIVECTL_RESET;
        upper_model    = MEM_UPPER_RESET;
        check_reset_state();
        run_register_traffic();
        exercise_i2c_drive();
        measure_clock_selects();
        run_memory_traffic();
        check_strobe_priority();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/nx4_clock_reset_gen.sv ====
`default_nettype none

module nx4_clock_reset_gen
    import nx4_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    input  wire logic [REG_DATA_W-1:0] drivectl,
    output logic                       pixel_clock,
    output logic                       grayscale_clock,
    output logic                       core_reset,
    output logic                       flash_reset_n
);

    logic [DIV_COUNT_W-1:0]    div_count;
    logic [DRIVECTL_SEL_W-1:0] pclk_sel;
    logic [DRIVECTL_SEL_W-1:0] gclk_sel;

    // select fields out of the drive control byte
    assign pclk_sel = drivectl[DRIVECTL_PCLK_LSB +: DRIVECTL_SEL_W];
    assign gclk_sel = drivectl[DRIVECTL_GCLK_LSB +: DRIVECTL_SEL_W];

    ////////////////////////////////////////////////////////////////////////////
    // free running divider and clock picks
    ////////////////////////////////////////////////////////////////////////////

    // bit n of the counter has a period of 2^(n+1) clocks
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            div_count       <= '0;
            pixel_clock     <= 1'b0;
            grayscale_clock <= 1'b0;
        end else begin
            div_count       <= div_count + 1'b1;
            pixel_clock     <= div_count[pclk_sel];
            grayscale_clock <= div_count[gclk_sel];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reset release
    ////////////////////////////////////////////////////////////////////////////

    // core reset is sticky low once the release bit has been seen
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            core_reset    <= 1'b1;
            flash_reset_n <= 1'b0;
        end else begin
            if (core_reset && div_count[RESET_RELEASE_BIT]) begin
                core_reset <= 1'b0;
            end
            // flash comes out of reset on the first edge
            flash_reset_n <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/nx4_memory_sequencer.sv ====
`default_nettype none

module nx4_memory_sequencer
    import nx4_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    arst_n,
    input  wire mem_req_t                mem_req,
    input  wire logic [UPPER_ADDR_W-1:0] mem_upper,
    input  wire logic [MEM_DATA_W-1:0]   mem_data_in,
    output mem_pins_t                    pins,
    output logic [MEM_DATA_W-1:0]        mem_rdata,
    output logic                         mem_busy
);

    logic [MEM_TIMER_W-1:0] cycle_timer;
    logic                   sram_sel;
    logic                   we_q;
    logic                   we_n_q;
    logic [CMD_ADDR_W-1:0]  cmd_addr_q;
    logic [MEM_DATA_W-1:0]  wdata_q;
    logic                   start_flash;
    logic                   start_sram;
    logic                   last_count;

    assign mem_busy = (cycle_timer != '0);

    // strobes only count while idle, flash has priority
    assign start_flash = !mem_busy && mem_req.flash_strobe;
    assign start_sram  = !mem_busy && !mem_req.flash_strobe && mem_req.sram_strobe;

    // final clock of a cycle, read data is sampled here
    assign last_count = (cycle_timer == MEM_TIMER_W'(1));

    ////////////////////////////////////////////////////////////////////////////
    // cycle timer and write strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cycle_timer <= '0;
            sram_sel    <= 1'b0;
            we_q        <= 1'b0;
            we_n_q      <= 1'b1;
        end else if (start_flash) begin
            // flash holds we_n high for the first clock to let the address settle
            cycle_timer <= MEM_TIMER_W'(FLASH_CYCLES);
            sram_sel    <= 1'b0;
            we_q        <= mem_req.we;
        end else if (start_sram) begin
            // sram write strobe runs for the whole single clock
            cycle_timer <= MEM_TIMER_W'(SRAM_CYCLES);
            sram_sel    <= 1'b1;
            we_q        <= mem_req.we;
            we_n_q      <= ~mem_req.we;
        end else if (mem_busy) begin
            cycle_timer <= cycle_timer - 1'b1;
            // release we_n two counts before the end, data latches on that rise
            if (cycle_timer <= MEM_TIMER_W'(2)) begin
                we_n_q <= 1'b1;
            end else begin
                we_n_q <= ~we_q;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request payload and read capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (start_flash || start_sram) begin
            cmd_addr_q <= mem_req.addr;
            wdata_q    <= mem_req.wdata;
        end
        if (mem_busy && last_count && !we_q) begin
            mem_rdata <= mem_data_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pin generation
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // both parts run 16 bit wide in byte mode, sram drops the low address bit
        if (sram_sel) begin
            pins.addr = {1'b0, mem_upper, cmd_addr_q[CMD_ADDR_W-1:1]};
        end else begin
            pins.addr = {mem_upper, cmd_addr_q};
        end
        pins.data_out   = wdata_q;
        pins.data_oe    = mem_busy && we_q;
        pins.we_n       = we_n_q;
        pins.sram_ce_n  = ~(mem_busy && sram_sel);
        pins.sram_oe_n  = ~(mem_busy && sram_sel && !we_q);
        // address bit 0 picks the sram byte lane
        pins.sram_bhe_n = ~cmd_addr_q[0];
        pins.sram_ble_n = cmd_addr_q[0];
        pins.flash_ce_n = ~(mem_busy && !sram_sel);
        pins.flash_oe_n = ~(mem_busy && !sram_sel && !we_q);
    end

endmodule

`default_nettype wire

// ==== source/nx4_pkg.sv ====
`default_nettype none

package nx4_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // register bank
    ////////////////////////////////////////////////////////////////////////////

    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 8;

    // register map, everything above REG_STATUS_HI reads as zero
    localparam logic [REG_ADDR_W-1:0] REG_IOCTL     = 4'd0;
    localparam logic [REG_ADDR_W-1:0] REG_DRIVECTL  = 4'd1;
    localparam logic [REG_ADDR_W-1:0] REG_MEM_UPPER = 4'd2;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS_LO = 4'd3;
    localparam logic [REG_ADDR_W-1:0] REG_STATUS_HI = 4'd4;

    // ioctl bits, 1 releases the line and 0 pulls it low
    localparam int IOCTL_BIT_SDA = 0;
    localparam int IOCTL_BIT_SCL = 1;

    // drivectl clock select fields
    localparam int DRIVECTL_PCLK_LSB = 0;
    localparam int DRIVECTL_GCLK_LSB = 3;
    localparam int DRIVECTL_SEL_W    = 3;

    localparam logic [REG_DATA_W-1:0] IOCTL_RESET     = 8'h03;
    localparam logic [REG_DATA_W-1:0] DRIVECTL_RESET  = 8'h01;
    localparam logic [REG_DATA_W-1:0] MEM_UPPER_RESET = 8'h00;

    ////////////////////////////////////////////////////////////////////////////
    // clocks, memory bus and status pins
    ////////////////////////////////////////////////////////////////////////////

    localparam int DIV_COUNT_W       = 8;
    localparam int RESET_RELEASE_BIT = 3;

    localparam int MEM_ADDR_W   = 21;
    localparam int CMD_ADDR_W   = 16;
    localparam int UPPER_ADDR_W = 5;
    localparam int MEM_DATA_W   = 8;

    // flash is stretched, sram completes in one clock
    localparam int FLASH_CYCLES = 7;
    localparam int SRAM_CYCLES  = 1;
    localparam int MEM_TIMER_W  = $clog2(FLASH_CYCLES + 1);

    localparam int STATUS_W = 12;

    typedef struct packed {
        logic                  write;
        logic                  read;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                  sram_strobe;
        logic                  flash_strobe;
        logic                  we;
        logic [CMD_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] data_out;
        logic                  data_oe;
        logic                  we_n;
        logic                  sram_ce_n;
        logic                  sram_oe_n;
        logic                  sram_bhe_n;
        logic                  sram_ble_n;
        logic                  flash_ce_n;
        logic                  flash_oe_n;
    } mem_pins_t;

    // cpld in the top bits, sda sampled back in bit 0
    typedef struct packed {
        logic [8:0] cpld;
        logic       flash_ry_by;
        logic       led_xerr;
        logic       i2c_sda;
    } status_pins_t;

endpackage

`default_nettype wire

// ==== source/nx4_register_bank.sv ====
`default_nettype none

module nx4_register_bank
    import nx4_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    arst_n,
    input  wire reg_req_t                reg_req,
    input  wire status_pins_t            status,
    output logic [REG_DATA_W-1:0]        reg_rdata,
    output logic [REG_DATA_W-1:0]        drivectl,
    output logic [UPPER_ADDR_W-1:0]      mem_upper,
    output logic                         i2c_sda_drive_low,
    output logic                         i2c_scl_drive_low
);

    logic [REG_DATA_W-1:0] ioctl;
    logic [REG_DATA_W-1:0] mem_upper_byte;
    logic [REG_DATA_W-1:0] read_mux;
    logic [STATUS_W-1:0]   status_bits;

    // flat view of the status pins for byte readback
    assign status_bits = status;

    ////////////////////////////////////////////////////////////////////////////
    // writable control bytes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ioctl          <= IOCTL_RESET;
            drivectl       <= DRIVECTL_RESET;
            mem_upper_byte <= MEM_UPPER_RESET;
        end else if (reg_req.write) begin
            // status and unused addresses drop the write
            case (reg_req.addr)
                REG_IOCTL:     ioctl          <= reg_req.wdata;
                REG_DRIVECTL:  drivectl       <= reg_req.wdata;
                REG_MEM_UPPER: mem_upper_byte <= reg_req.wdata;
                default: ;
            endcase
        end
    end

    // only the page bits reach the sequencer
    assign mem_upper = mem_upper_byte[UPPER_ADDR_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // readback
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (reg_req.addr)
            REG_IOCTL:     read_mux = ioctl;
            REG_DRIVECTL:  read_mux = drivectl;
            REG_MEM_UPPER: read_mux = mem_upper_byte;
            REG_STATUS_LO: read_mux = status_bits[7:0];
            // upper nibble of the status vector, zero filled
            REG_STATUS_HI: read_mux = {4'h0, status_bits[STATUS_W-1:8]};
            default:       read_mux = '0;
        endcase
    end

    // readback holds until the next read strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else if (reg_req.read) begin
            reg_rdata <= read_mux;
        end
    end

    // open drain i2c, pull low when the control bit is clear
    assign i2c_sda_drive_low = ~ioctl[IOCTL_BIT_SDA];
    assign i2c_scl_drive_low = ~ioctl[IOCTL_BIT_SCL];

endmodule

`default_nettype wire

// ==== source/nx4_tile_core.sv ====
`default_nettype none

module nx4_tile_core
    import nx4_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  arst_n,

    // register access
    input  wire reg_req_t              reg_req,
    output logic [REG_DATA_W-1:0]      reg_rdata,
    input  wire status_pins_t          status,
    output logic                       i2c_sda_drive_low,
    output logic                       i2c_scl_drive_low,

    // generated clocks and resets
    output logic                       pixel_clock,
    output logic                       grayscale_clock,
    output logic                       core_reset,
    output logic                       flash_reset_n,

    // shared sram/flash bus
    input  wire mem_req_t              mem_req,
    output logic [MEM_DATA_W-1:0]      mem_rdata,
    output logic                       mem_busy,
    output mem_pins_t                  mem_pins,
    input  wire logic [MEM_DATA_W-1:0] mem_data_in
);

    logic [REG_DATA_W-1:0]   drivectl;
    logic [UPPER_ADDR_W-1:0] mem_upper;

    ////////////////////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////////////////////

    nx4_register_bank i_register_bank (
        .clock             (clock),
        .arst_n            (arst_n),
        .reg_req           (reg_req),
        .status            (status),
        .reg_rdata         (reg_rdata),
        .drivectl          (drivectl),
        .mem_upper         (mem_upper),
        .i2c_sda_drive_low (i2c_sda_drive_low),
        .i2c_scl_drive_low (i2c_scl_drive_low)
    );

    // clock selects come from drivectl
    nx4_clock_reset_gen i_clock_reset_gen (
        .clock           (clock),
        .arst_n          (arst_n),
        .drivectl        (drivectl),
        .pixel_clock     (pixel_clock),
        .grayscale_clock (grayscale_clock),
        .core_reset      (core_reset),
        .flash_reset_n   (flash_reset_n)
    );

    // page bits from the upper address register
    nx4_memory_sequencer i_memory_sequencer (
        .clock       (clock),
        .arst_n      (arst_n),
        .mem_req     (mem_req),
        .mem_upper   (mem_upper),
        .mem_data_in (mem_data_in),
        .pins        (mem_pins),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy)
    );

endmodule

`default_nettype wire
